/* src/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath word width
`define DATA_WIDTH 32

// R0..R15 plus the return register
`define NUM_REGS 17

// return / stack register index
`define RET_REG 16

// value the return register takes on reset
`define RET_RESET 1023

// clocks each display digit stays lit
// kept tiny so simulation sees the scan turn over quickly
`define SCAN_DIV 4

`endif

/* src/coreTypes_pkg.sv */
`default_nettype none

package coreTypes_pkg;

    `include "core_defines.svh"

    // signed data word as held in the register bank
    typedef logic signed [`DATA_WIDTH-1:0] word_t;

    // register index, wide enough for all banked registers
    typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;

    // raw immediate field of the instruction word
    typedef logic [15:0] imm_t;

    // opcode field, bits 31:26
    // values not listed here are illegal and never write
    typedef enum logic [5:0] {
        OP_ADD  = 6'd0,
        OP_SUB  = 6'd1,
        OP_AND  = 6'd2,
        OP_OR   = 6'd3,
        OP_XOR  = 6'd4,
        OP_SLT  = 6'd5,
        OP_ADDI = 6'd8,
        OP_LUI  = 6'd9
    } opcode_e;

    // operation the ALU applies to its operands
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluOp_e;

endpackage

`default_nettype wire

/* src/display_pkg.sv */
`default_nettype none

package display_pkg;

    // one hex digit of the display word
    typedef logic [3:0] hexDigit_t;

    // segment drive, active low
    // bit order gfedcba, so bit 0 is segment a
    typedef logic [6:0] segments_t;

    // which of the four digits is lit
    typedef logic [1:0] digitSel_t;

    // scan position, one state per digit
    // encoding equals the digit select value
    typedef enum digitSel_t {
        SCAN_DIG0 = 2'd0,
        SCAN_DIG1 = 2'd1,
        SCAN_DIG2 = 2'd2,
        SCAN_DIG3 = 2'd3
    } scanState_e;

endpackage

`default_nettype wire

/* src/regFile_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface regFile_if;

    // read and write indices
    coreTypes_pkg::regIdx_t rs;
    coreTypes_pkg::regIdx_t rt;
    coreTypes_pkg::regIdx_t destReg;

    // write strobe and write-back value
    logic                 wrReg;
    coreTypes_pkg::word_t wrData;

    // combinational read data
    coreTypes_pkg::word_t rdData1;
    coreTypes_pkg::word_t rdData2;

    // decoder side, picks registers and raises the strobe
    modport ctrl (output rs, rt, destReg, wrReg);

    // ALU side, consumes operands and returns the write-back value
    modport exec (input rdData1, rdData2, output wrData);

    // register bank itself
    modport bank (input rs, rt, destReg, wrReg, wrData, output rdData1, rdData2);

endinterface

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  coreTypes_pkg::word_t  instr,
    input  logic                  instrValid,
    regFile_if.ctrl               regs,
    output coreTypes_pkg::aluOp_e aluOp,
    output logic                  useImm,
    output coreTypes_pkg::word_t  immExt
);

    coreTypes_pkg::opcode_e opcode;
    coreTypes_pkg::imm_t    imm;
    logic                   legal;

    // field split
    // rt and imm overlap, the opcode decides which one matters
    assign opcode       = coreTypes_pkg::opcode_e'(instr[31:26]);
    assign regs.destReg = instr[25:21];
    assign regs.rs      = instr[20:16];
    assign regs.rt      = instr[15:11];
    assign imm          = instr[15:0];

    // sign extend to a full word
    assign immExt = coreTypes_pkg::word_t'(signed'(imm));

    // opcode to ALU operation and operand select
    always_comb begin
        legal  = 1'b1;
        useImm = 1'b0;
        aluOp  = coreTypes_pkg::ALU_ADD;
        case (opcode)
            coreTypes_pkg::OP_ADD: begin
                aluOp = coreTypes_pkg::ALU_ADD;
            end
            coreTypes_pkg::OP_SUB: begin
                aluOp = coreTypes_pkg::ALU_SUB;
            end
            coreTypes_pkg::OP_AND: begin
                aluOp = coreTypes_pkg::ALU_AND;
            end
            coreTypes_pkg::OP_OR: begin
                aluOp = coreTypes_pkg::ALU_OR;
            end
            coreTypes_pkg::OP_XOR: begin
                aluOp = coreTypes_pkg::ALU_XOR;
            end
            coreTypes_pkg::OP_SLT: begin
                aluOp = coreTypes_pkg::ALU_SLT;
            end
            // addi is an add against the immediate
            coreTypes_pkg::OP_ADDI: begin
                aluOp  = coreTypes_pkg::ALU_ADD;
                useImm = 1'b1;
            end
            coreTypes_pkg::OP_LUI: begin
                aluOp  = coreTypes_pkg::ALU_LUI;
                useImm = 1'b1;
            end
            // unknown opcode, no write
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // strobe only for a valid, legal instruction
    // out-of-range destReg is filtered in the bank
    assign regs.wrReg = instrValid && legal;

endmodule

`default_nettype wire

/* src/aluUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  logic                  clk,
    input  logic                  rst,
    regFile_if.exec               regs,
    input  coreTypes_pkg::aluOp_e aluOp,
    input  logic                  useImm,
    input  coreTypes_pkg::word_t  immExt,
    input  logic                  wrReg,
    output coreTypes_pkg::word_t  result,
    output logic                  resultValid
);

    coreTypes_pkg::word_t opA;
    coreTypes_pkg::word_t opB;

    // second operand is the register or the extended immediate
    assign opA = regs.rdData1;
    assign opB = useImm ? immExt : regs.rdData2;

    // write-back value, goes straight to the bank
    always_comb begin
        case (aluOp)
            coreTypes_pkg::ALU_ADD: regs.wrData = opA + opB;
            coreTypes_pkg::ALU_SUB: regs.wrData = opA - opB;
            coreTypes_pkg::ALU_AND: regs.wrData = opA & opB;
            coreTypes_pkg::ALU_OR:  regs.wrData = opA | opB;
            coreTypes_pkg::ALU_XOR: regs.wrData = opA ^ opB;
            // both operands are signed words, so this is a signed compare
            coreTypes_pkg::ALU_SLT: regs.wrData = (opA < opB) ? 1 : 0;
            // immediate into the upper half, rs ignored
            coreTypes_pkg::ALU_LUI: regs.wrData = {immExt[15:0], 16'h0000};
            default:                regs.wrData = '0;
        endcase
    end

    // valid pulse one cycle after the write edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= wrReg;
        end
    end

    // result holds the last written value between instructions
    always_ff @(posedge clk) begin
        if (wrReg) begin
            result <= regs.wrData;
        end
    end

endmodule

`default_nettype wire

/* src/regBank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module regBank (
    input  logic        clk,
    input  logic        rst,
    regFile_if.bank     regs,
    output logic [15:0] disp
);

    // register shown on the display
    localparam int DISP_REG = 2;

    // R0 has no storage, it reads as zero
    coreTypes_pkg::word_t regArray [1:`NUM_REGS-1];

    // true for an index that maps to real storage
    function automatic logic inRange(input coreTypes_pkg::regIdx_t idx);
        return (idx != 0) && (idx < `NUM_REGS);
    endfunction

    // combinational reads, zero for R0 or out of range
    assign regs.rdData1 = inRange(regs.rs) ? regArray[regs.rs] : '0;
    assign regs.rdData2 = inRange(regs.rt) ? regArray[regs.rt] : '0;

    // write port
    // writes to R0 or beyond the bank are dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regArray[i] <= (i == `RET_REG) ? `RET_RESET : 0;
            end
        end else if (regs.wrReg && inRange(regs.destReg)) begin
            regArray[regs.destReg] <= regs.wrData;
        end
    end

    // display copy of R2, one cycle behind a write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            disp <= '0;
        end else begin
            disp <= regArray[DISP_REG][15:0];
        end
    end

endmodule

`default_nettype wire

/* src/hexDisplayScan.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module hexDisplayScan (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [15:0]             disp,
    output display_pkg::segments_t  seg,
    output logic [3:0]              an
);

    // divider width, at least one bit
    localparam int DIV_W = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;

    logic [DIV_W-1:0]        divCnt;
    logic                    divTick;
    display_pkg::scanState_e state;
    display_pkg::digitSel_t  digitSel;
    display_pkg::hexDigit_t  nibble;

    // end of one digit period
    assign divTick = (divCnt == DIV_W'(`SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            divCnt <= '0;
            state  <= display_pkg::SCAN_DIG0;
        end else if (divTick) begin
            divCnt <= '0;
            // round robin over the four digits
            case (state)
                display_pkg::SCAN_DIG0: state <= display_pkg::SCAN_DIG1;
                display_pkg::SCAN_DIG1: state <= display_pkg::SCAN_DIG2;
                display_pkg::SCAN_DIG2: state <= display_pkg::SCAN_DIG3;
                default:                state <= display_pkg::SCAN_DIG0;
            endcase
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // digit 0 is the rightmost, low nibble
    assign digitSel = state;
    assign nibble   = disp[digitSel*4 +: 4];

    // one anode low at a time
    assign an = ~(4'b0001 << digitSel);

    // hex glyphs, gfedcba, active low
    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            // lower case b and d, so they differ from 8 and 0
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

/* src/execCore.sv */
`timescale 1ns/10ps
`default_nettype none

module execCore (
    input  logic                   clk,
    input  logic                   rst,
    input  coreTypes_pkg::word_t   instr,
    input  logic                   instrValid,
    output coreTypes_pkg::word_t   result,
    output logic                   resultValid,
    output logic [15:0]            disp,
    output display_pkg::segments_t seg,
    output logic [3:0]             an
);

    // decoder to ALU side channel
    coreTypes_pkg::aluOp_e aluOp;
    logic                  useImm;
    coreTypes_pkg::word_t  immExt;

    // shared register bank bus
    regFile_if regs ();

    // instruction word into indices and operation
    instrDecoder decoder0 (
        .instr      (instr),
        .instrValid (instrValid),
        .regs       (regs.ctrl),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .immExt     (immExt)
    );

    // write-back value and registered result
    aluUnit alu0 (
        .clk         (clk),
        .rst         (rst),
        .regs        (regs.exec),
        .aluOp       (aluOp),
        .useImm      (useImm),
        .immExt      (immExt),
        .wrReg       (regs.wrReg),
        .result      (result),
        .resultValid (resultValid)
    );

    // register storage, also feeds the display word
    regBank bank0 (
        .clk  (clk),
        .rst  (rst),
        .regs (regs.bank),
        .disp (disp)
    );

    // four-digit multiplexed display of R2
    hexDisplayScan scan0 (
        .clk  (clk),
        .rst  (rst),
        .disp (disp),
        .seg  (seg),
        .an   (an)
    );

endmodule

`default_nettype wire

/* testbench/tb_execCore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module tb_execCore;

    localparam int NUM_TABLE    = 20;
    localparam int NUM_RANDOM   = 32;
    localparam int RESET_CYCLES = 8;
    // sync to a digit change, then two full scan rounds
    localparam int SCAN_CYCLES  = 9 * `SCAN_DIV + 2;
    localparam int CYCLE_LIMIT  = 2 * (NUM_TABLE + NUM_RANDOM) + RESET_CYCLES + SCAN_CYCLES;

    // opcode values of the ISA
    localparam logic [5:0] OPC_ADD  = 6'd0;
    localparam logic [5:0] OPC_SUB  = 6'd1;
    localparam logic [5:0] OPC_AND  = 6'd2;
    localparam logic [5:0] OPC_OR   = 6'd3;
    localparam logic [5:0] OPC_XOR  = 6'd4;
    localparam logic [5:0] OPC_SLT  = 6'd5;
    localparam logic [5:0] OPC_ADDI = 6'd8;
    localparam logic [5:0] OPC_LUI  = 6'd9;

    // lit segments gfedcba per hex digit with F in the top slot
    localparam logic [111:0] GLYPHS = {
        7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f, 7'h7f,
        7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f
    };

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        instrValid;
    logic [31:0] result;
    logic        resultValid;
    logic [15:0] disp;
    logic [6:0]  seg;
    logic [3:0]  an;

    // reference register file and bookkeeping
    logic [31:0] model [0:16];
    logic [31:0] lastResult;
    logic        haveResult;
    logic [31:0] randState;
    int          cycleCount = 0;

    // stimulus table with hand-worked expectations
    logic [31:0] tabInstr [NUM_TABLE];
    logic        tabValid [NUM_TABLE];
    logic        tabExpV  [NUM_TABLE];
    logic [31:0] tabExpR  [NUM_TABLE];
    int          tabFill = 0;

    execCore dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instrValid  (instrValid),
        .result      (result),
        .resultValid (resultValid),
        .disp        (disp),
        .seg         (seg),
        .an          (an)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    // watchdog
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            abortRun();
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // R0 and indices past R16 read zero
    function automatic logic [31:0] readModel(input logic [4:0] idx);
        return (idx == 0 || idx > 16) ? 32'd0 : model[idx];
    endfunction

    function automatic logic isLegal(input logic [5:0] op);
        return (op <= OPC_SLT) || (op == OPC_ADDI) || (op == OPC_LUI);
    endfunction

    // write-back value from the ISA rules
    function automatic logic [31:0] predict(input logic [5:0] op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [15:0] imm);
        logic [31:0] opB;
        opB = (op == OPC_ADDI) ? {{16{imm[15]}}, imm} : b;
        case (op)
            OPC_ADD, OPC_ADDI: return a + opB;
            OPC_SUB: return a - opB;
            OPC_AND: return a & opB;
            OPC_OR:  return a | opB;
            OPC_XOR: return a ^ opB;
            OPC_SLT: return ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
            OPC_LUI: return {imm, 16'h0000};
            default: return 32'd0;
        endcase
    endfunction

    task automatic addStep(input logic [5:0] op, input logic [4:0] rd, input logic [4:0] rs,
                           input logic [15:0] low, input logic valid, input logic expV,
                           input logic [31:0] expR);
        tabInstr[tabFill] = {op, rd, rs, low};
        tabValid[tabFill] = valid;
        tabExpV[tabFill]  = expV;
        tabExpR[tabFill]  = expR;
        tabFill++;
    endtask

    // entered 5 ns after an edge and returns 5 ns after the next one
    task automatic runStep(input logic [31:0] word, input logic valid, input int stepNo);
        logic [4:0]  rd;
        logic        expV;
        logic [31:0] expR;
        logic [15:0] expDisp;
        rd      = word[25:21];
        expV    = valid && isLegal(word[31:26]);
        expR    = predict(word[31:26], readModel(word[20:16]), readModel(word[15:11]),
                          word[15:0]);
        // disp lags R2 by one edge
        expDisp = model[2][15:0];
        instr      = word;
        instrValid = valid;
        @(posedge clk);
        #5;
        assert (resultValid === expV) else begin
            $display("ERROR at %0t: step %0d resultValid %b, expected %b",
                     $time, stepNo, resultValid, expV);
            abortRun();
        end
        if (expV) begin
            assert (result === expR) else begin
                $display("ERROR at %0t: step %0d result %h, expected %h",
                         $time, stepNo, result, expR);
                abortRun();
            end
            lastResult = expR;
            haveResult = 1'b1;
            if (rd != 0 && rd <= 16) begin
                model[rd] = expR;
            end
        end else if (haveResult) begin
            // no write, so result must hold
            assert (result === lastResult) else begin
                $display("ERROR at %0t: step %0d result moved to %h, expected %h",
                         $time, stepNo, result, lastResult);
                abortRun();
            end
        end
        assert (disp === expDisp) else begin
            $display("ERROR at %0t: step %0d disp %h, expected %h", $time, stepNo, disp, expDisp);
            abortRun();
        end
    endtask

    initial begin
        logic [5:0]  op;
        logic [3:0]  nib;
        int          d;
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        haveResult = 1'b0;
        randState  = 32'hab01f934;
        for (int r = 0; r <= 16; r++) begin
            model[r] = (r == 16) ? 32'd1023 : 32'd0;
        end

        // op, rd, rs, low half (rt sits in bits 15:11), valid, expected valid, expected result
        addStep(OPC_ADD,  2,  16, 16'h0000, 1, 1, 32'd1023);
        addStep(OPC_ADDI, 3,  2,  16'd5,    1, 1, 32'd1028);
        addStep(OPC_ADDI, 4,  0,  16'hfffd, 1, 1, 32'hfffffffd);
        addStep(OPC_SUB,  5,  3,  16'h2000, 1, 1, 32'd1031);
        addStep(OPC_AND,  6,  5,  16'h8000, 1, 1, 32'd7);
        addStep(OPC_OR,   7,  6,  16'h2000, 1, 1, 32'hffffffff);
        addStep(OPC_XOR,  8,  7,  16'h1800, 1, 1, 32'hfffffbfb);
        addStep(OPC_SLT,  9,  4,  16'h3000, 1, 1, 32'd1);
        addStep(OPC_SLT,  10, 6,  16'h2000, 1, 1, 32'd0);
        // rs of lui is ignored
        addStep(OPC_LUI,  2,  5,  16'h1234, 1, 1, 32'h12340000);
        addStep(OPC_ADDI, 2,  2,  16'h5678, 1, 1, 32'h12345678);
        addStep(OPC_ADD,  0,  3,  16'h1800, 1, 1, 32'd2056);
        addStep(OPC_ADD,  1,  0,  16'h8000, 1, 1, 32'd1023);
        addStep(OPC_ADDI, 17, 16, 16'd1,    1, 1, 32'd1024);
        addStep(OPC_ADDI, 11, 17, 16'd100,  1, 1, 32'd100);
        addStep(OPC_ADDI, 12, 0,  16'd55,   0, 0, 32'd100);
        addStep(6'd7,     12, 16, 16'h8000, 1, 0, 32'd100);
        addStep(OPC_ADD,  12, 12, 16'h8000, 1, 1, 32'd1023);
        addStep(OPC_SUB,  13, 0,  16'h8000, 1, 1, 32'hfffffc01);
        addStep(OPC_SLT,  14, 13, 16'h0800, 1, 1, 32'd1);

        repeat (RESET_CYCLES) @(posedge clk);
        assert (an === 4'b1110) else begin
            $display("ERROR at %0t: an %b during reset, expected 1110", $time, an);
            abortRun();
        end
        #5 rst = 1'b0;
        @(posedge clk);
        #5;
        assert (disp === 16'h0000 && resultValid === 1'b0) else begin
            $display("ERROR at %0t: after reset disp %h resultValid %b", $time, disp, resultValid);
            abortRun();
        end

        for (int i = 0; i < NUM_TABLE; i++) begin
            runStep(tabInstr[i], tabValid[i], i);
            assert (resultValid === tabExpV[i] &&
                    (!tabExpV[i] || result === tabExpR[i])) else begin
                $display("ERROR at %0t: row %0d gave %b/%h, table says %b/%h",
                         $time, i, resultValid, result, tabExpV[i], tabExpR[i]);
                abortRun();
            end
        end

        // random addi, lui and register forms with rd and rs allowed past R16
        for (int i = 0; i < NUM_RANDOM; i++) begin
            randState = lcgNext(randState);
            case (randState[31:30])
                2'd0:    op = OPC_ADDI;
                2'd1:    op = OPC_LUI;
                default: op = 6'(randState[29:27] % 6);
            endcase
            runStep({op, 5'(randState[25:21] % 19), 5'(randState[20:16] % 19), randState[15:0]},
                    1'b1, NUM_TABLE + i);
        end

        // four distinct nibbles in R2 so a wrong digit select shows on seg
        runStep({OPC_ADDI, 5'd2, 5'd0, 16'h1234}, 1'b1, NUM_TABLE + NUM_RANDOM);
        instrValid = 1'b0;

        // wait for a digit change, then follow two rounds
        nib = an;
        while (an === nib) begin
            @(posedge clk);
            #5;
        end
        d = -1;
        for (int j = 0; j < 4; j++) begin
            if (an === ~(4'b0001 << j)) begin
                d = j;
            end
        end
        assert (d >= 0) else begin
            $display("ERROR at %0t: an %b selects no single digit", $time, an);
            abortRun();
        end
        for (int k = 0; k < 8; k++) begin
            for (int c = 0; c < `SCAN_DIV; c++) begin
                nib = disp[d*4 +: 4];
                assert (an === ~(4'b0001 << d) && seg === ~GLYPHS[nib*7 +: 7]) else begin
                    $display("ERROR at %0t: digit %0d an %b seg %b for nibble %h",
                             $time, d, an, seg, nib);
                    abortRun();
                end
                @(posedge clk);
                #5;
            end
            d = (d + 1) % 4;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/coreTypes_pkg.sv
src/display_pkg.sv
src/regFile_if.sv
src/instrDecoder.sv
src/aluUnit.sv
src/regBank.sv
src/hexDisplayScan.sv
src/execCore.sv
testbench/tb_execCore.sv

/* Bender.yml */
package:
  name: exec_core

export_include_dirs:
  - src

sources:
  - src/coreTypes_pkg.sv
  - src/display_pkg.sv
  - src/regFile_if.sv
  - src/instrDecoder.sv
  - src/aluUnit.sv
  - src/regBank.sv
  - src/hexDisplayScan.sv
  - src/execCore.sv
  - target: test
    files:
      - testbench/tb_execCore.sv
